/* hdl/conv_pkg.sv */
`default_nettype none

package conv_pkg;

   // data widths
   localparam int PIX_W  = 16;   // pixel, weight, bias and result
   localparam int PROD_W = 32;   // one signed 16x16 product

   // nine 32-bit products need four guard bits
   localparam int ACC_W  = 36;

   // kernel geometry
   localparam int KSIZE = 3;             // window side
   localparam int NTAPS = KSIZE * KSIZE; // taps per window

   // fixed point
   localparam int QF = 8;  // fraction bits of the weights

   // frame geometry limits
   localparam int MAX_LINE = 64;  // line memory depth
   localparam int LEN_W    = 7;   // line length and line count inputs

   // registered stages behind the window, product, sum and output
   localparam int PIPE_DEPTH = 3;

   // frame control states
   typedef enum logic [1:0] {
      IDLE    = 2'd0,
      PRELOAD = 2'd1,  // filling the first two lines
      RUN     = 2'd2,  // every accepted pixel may close a window
      FLUSH   = 2'd3   // input done, pipeline draining
   } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/conv_ctrl_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_ctrl_fsm import conv_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             start_i,
   input  logic [LEN_W-1:0] line_len_i,
   input  logic [LEN_W-1:0] n_lines_i,
   input  logic             pix_accept_i,
   input  logic             advance_i,
   input  logic             out_valid_i,
   output ctrl_state_t      state_o,
   output logic             accept_en_o,
   output logic             lb_clear_o,
   output logic             done_preload_o,
   output logic             busy_o,
   output logic             done_o
);

   ctrl_state_t        state_q;
   logic [2*LEN_W-1:0] pix_cnt_q;
   logic [2*LEN_W-1:0] pix_cnt_nxt;
   logic [2*LEN_W-1:0] total_q;    // pixels in the frame
   logic [2*LEN_W-1:0] preload_q;  // two lines plus two pixels
   logic [LEN_W-1:0]   flush_cnt_q;
   logic               drained;

   assign pix_cnt_nxt = pix_cnt_q + 1'b1;

   // last result has left the output register
   assign drained = (flush_cnt_q == '0) && !out_valid_i;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q     <= IDLE;
         pix_cnt_q   <= '0;
         total_q     <= '0;
         preload_q   <= '0;
         flush_cnt_q <= '0;
         done_o      <= 1'b0;
      end else begin
         done_o <= 1'b0;
         case (state_q)
            IDLE: begin
               if (start_i) begin
                  state_q   <= PRELOAD;
                  pix_cnt_q <= '0;
                  total_q   <= (2*LEN_W)'(line_len_i) * (2*LEN_W)'(n_lines_i);
                  preload_q <= ((2*LEN_W)'(line_len_i) << 1) + 2'd2;
               end
            end
            PRELOAD: begin
               if (pix_accept_i) begin
                  pix_cnt_q <= pix_cnt_nxt;
                  if (pix_cnt_nxt == preload_q) state_q <= RUN;
               end
            end
            RUN: begin
               if (pix_accept_i) begin
                  pix_cnt_q <= pix_cnt_nxt;
                  if (pix_cnt_nxt == total_q) begin
                     state_q     <= FLUSH;
                     flush_cnt_q <= LEN_W'(PIPE_DEPTH);
                  end
               end
            end
            FLUSH: begin
               // only advancing cycles move the last window along
               if (advance_i && (flush_cnt_q != '0)) flush_cnt_q <= flush_cnt_q - 1'b1;
               if (drained) begin
                  state_q <= IDLE;
                  done_o  <= 1'b1;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   assign state_o        = state_q;
   assign accept_en_o    = (state_q == PRELOAD) || (state_q == RUN);
   assign lb_clear_o     = (state_q == IDLE) && start_i;  // same edge as the geometry latch
   assign done_preload_o = (state_q == RUN) || (state_q == FLUSH);
   assign busy_o         = (state_q != IDLE);

   // one-cycle done pulse
   a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done_o |=> !done_o);

endmodule

`default_nettype wire

/* hdl/conv_linebuffer.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_linebuffer import conv_pkg::*; (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        clear_i,
   input  logic [LEN_W-1:0]            line_len_i,
   input  logic                        pix_valid_i,
   input  logic [PIX_W-1:0]            pix_i,
   input  logic                        advance_i,
   output logic                        win_valid_o,
   output logic [NTAPS-1:0][PIX_W-1:0] win_o
);

   logic [LEN_W-1:0] len_q;
   logic [LEN_W-1:0] col_q;
   logic [LEN_W-1:0] row_q;
   logic             last_col;
   logic             covered;

   // row r-1 and row r-2, addressed by column
   logic [PIX_W-1:0] line0_mem [MAX_LINE];
   logic [PIX_W-1:0] line1_mem [MAX_LINE];
   logic [$clog2(MAX_LINE)-1:0] lb_addr;
   logic [PIX_W-1:0] above1;
   logic [PIX_W-1:0] above2;

   // [row][col], row 0 oldest line, col 2 newest pixel
   logic [KSIZE-1:0][KSIZE-1:0][PIX_W-1:0] win_q;
   logic [KSIZE-1:0][PIX_W-1:0]            new_col;

   assign lb_addr  = col_q[$clog2(MAX_LINE)-1:0];
   assign above1   = line0_mem[lb_addr];
   assign above2   = line1_mem[lb_addr];
   assign last_col = (col_q == len_q - 1'b1);

   // pixel closes a window only with two columns and two rows behind it
   assign covered = (col_q >= LEN_W'(KSIZE - 1)) && (row_q >= LEN_W'(KSIZE - 1));

   assign new_col[0] = above2;
   assign new_col[1] = above1;
   assign new_col[2] = pix_i;

   // raster position
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         len_q <= '0;
         col_q <= '0;
         row_q <= '0;
      end else if (clear_i) begin
         len_q <= line_len_i;
         col_q <= '0;
         row_q <= '0;
      end else if (pix_valid_i) begin
         if (last_col) begin
            col_q <= '0;
            row_q <= row_q + 1'b1;
         end else begin
            col_q <= col_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         win_valid_o <= 1'b0;
      end else if (clear_i) begin
         win_valid_o <= 1'b0;
      end else if (advance_i) begin
         win_valid_o <= pix_valid_i && covered;  // drops once the window moves on
      end
   end

   // line memories, row r-1 slides down into row r-2
   always_ff @(posedge clk) begin
      if (pix_valid_i) begin
         line0_mem[lb_addr] <= pix_i;
         line1_mem[lb_addr] <= above1;
      end
   end

   always_ff @(posedge clk) begin
      if (pix_valid_i) begin
         for (int r = 0; r < KSIZE; r++) begin
            win_q[r][0] <= win_q[r][1];
            win_q[r][1] <= win_q[r][2];
            win_q[r][2] <= new_col[r];
         end
      end
   end

   assign win_o = win_q;  // tap 0 top left, raster order

   // pixels only flow after the FSM has left idle
   a_no_pix_on_clear: assert property (
      @(posedge clk) disable iff (!rst_n) clear_i |-> !pix_valid_i);

endmodule

`default_nettype wire

/* hdl/conv_sop.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_sop import conv_pkg::*; (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        advance_i,
   input  logic                        valid_i,
   input  logic [NTAPS-1:0][PIX_W-1:0] win_i,
   input  logic [NTAPS-1:0][PIX_W-1:0] weights_i,
   output logic                        valid_o,
   output logic [ACC_W-1:0]            sum_o
);

   logic signed [PROD_W-1:0] prod_q [NTAPS];
   logic                     prod_valid_q;
   logic signed [ACC_W-1:0]  acc;

   // stage 1, nine signed multipliers
   always_ff @(posedge clk) begin
      if (advance_i && valid_i) begin
         for (int i = 0; i < NTAPS; i++) begin
            prod_q[i] <= $signed(win_i[i]) * $signed(weights_i[i]);
         end
      end
   end

   // adder tree over the sign-extended products
   always_comb begin
      acc = '0;
      for (int i = 0; i < NTAPS; i++) begin
         acc = acc + ACC_W'(prod_q[i]);
      end
   end

   // stage 2, registered sum
   always_ff @(posedge clk) begin
      if (advance_i && prod_valid_q) begin
         sum_o <= acc;
      end
   end

   // valid travels beside the data
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         prod_valid_q <= 1'b0;
         valid_o      <= 1'b0;
      end else if (advance_i) begin
         prod_valid_q <= valid_i;
         valid_o      <= prod_valid_q;
      end
   end

   a_valid_known: assert property (
      @(posedge clk) disable iff (!rst_n) !$isunknown(valid_o));

endmodule

`default_nettype wire

/* hdl/conv_out_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_out_stage import conv_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             advance_i,
   input  logic             valid_i,
   input  logic [ACC_W-1:0] sum_i,
   input  logic [PIX_W-1:0] bias_i,
   input  logic             rectify_i,
   input  logic             y_ready_i,
   output logic             y_valid_o,
   output logic [PIX_W-1:0] y_data_o
);

   logic signed [ACC_W-1:0] bias_ext;
   logic signed [ACC_W-1:0] biased;
   logic signed [ACC_W-1:0] scaled;
   logic                    fits;
   logic [PIX_W-1:0]        result;

   // bias is an integer, align it with the QF fraction of the sum
   assign bias_ext = ACC_W'($signed(bias_i)) <<< QF;
   assign biased   = $signed(sum_i) + bias_ext;
   assign scaled   = biased >>> QF;

   // upper bits all equal the sign, no overflow
   assign fits = (scaled[ACC_W-1:PIX_W-1] == {(ACC_W-PIX_W+1){scaled[ACC_W-1]}});

   always_comb begin
      if (rectify_i && scaled[ACC_W-1]) begin
         result = '0;
      end else if (!fits) begin
         // clamp to the signed 16-bit limits
         result = scaled[ACC_W-1] ? {1'b1, {(PIX_W-1){1'b0}}} : {1'b0, {(PIX_W-1){1'b1}}};
      end else begin
         result = scaled[PIX_W-1:0];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         y_valid_o <= 1'b0;
      end else if (advance_i) begin
         y_valid_o <= valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (advance_i && valid_i) begin
         y_data_o <= result;
      end
   end

   // a stalled result holds until taken
   a_hold_stalled: assert property (
      @(posedge clk) disable iff (!rst_n)
      (y_valid_o && !y_ready_i) |=> (y_valid_o && $stable(y_data_o)));

endmodule

`default_nettype wire

/* hdl/conv_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_engine import conv_pkg::*; (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        start_i,
   input  logic [LEN_W-1:0]            line_len_i,
   input  logic [LEN_W-1:0]            n_lines_i,
   input  logic [NTAPS-1:0][PIX_W-1:0] weights_i,
   input  logic [PIX_W-1:0]            bias_i,
   input  logic                        rectify_i,
   input  logic                        x_valid_i,
   input  logic [PIX_W-1:0]            x_data_i,
   input  logic                        y_ready_i,
   output logic                        x_ready_o,
   output logic                        y_valid_o,
   output logic [PIX_W-1:0]            y_data_o,
   output logic                        busy_o,
   output logic                        done_preload_o,
   output logic                        done_o
);

   ctrl_state_t                 state;
   logic                        accept_en;
   logic                        lb_clear;
   logic                        advance;
   logic                        pix_accept;
   logic                        win_valid;
   logic [NTAPS-1:0][PIX_W-1:0] win;
   logic                        sop_valid;
   logic [ACC_W-1:0]            sop_sum;

   // one enable for the whole pipeline
   assign advance    = !y_valid_o || y_ready_i;
   assign x_ready_o  = accept_en && advance;
   assign pix_accept = x_valid_i && x_ready_o;

   conv_ctrl_fsm ctrl_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .start_i        (start_i),
      .line_len_i     (line_len_i),
      .n_lines_i      (n_lines_i),
      .pix_accept_i   (pix_accept),
      .advance_i      (advance),
      .out_valid_i    (y_valid_o),
      .state_o        (state),
      .accept_en_o    (accept_en),
      .lb_clear_o     (lb_clear),
      .done_preload_o (done_preload_o),
      .busy_o         (busy_o),
      .done_o         (done_o)
   );

   conv_linebuffer lb_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .clear_i     (lb_clear),
      .line_len_i  (line_len_i),
      .pix_valid_i (pix_accept),
      .pix_i       (x_data_i),
      .advance_i   (advance),
      .win_valid_o (win_valid),
      .win_o       (win)
   );

   conv_sop sop_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .advance_i (advance),
      .valid_i   (win_valid),
      .win_i     (win),
      .weights_i (weights_i),
      .valid_o   (sop_valid),
      .sum_o     (sop_sum)
   );

   conv_out_stage out_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .advance_i (advance),
      .valid_i   (sop_valid),
      .sum_i     (sop_sum),
      .bias_i    (bias_i),
      .rectify_i (rectify_i),
      .y_ready_i (y_ready_i),
      .y_valid_o (y_valid_o),
      .y_data_o  (y_data_o)
   );

   // idle engine offers no result
   a_idle_quiet: assert property (
      @(posedge clk) disable iff (!rst_n) (state == IDLE) |-> !y_valid_o);

endmodule

`default_nettype wire

/* tb/conv_engine_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_engine_tb import conv_pkg::*; ();

   localparam int CLK_PERIOD = 40;
   // pixels over all frames, back-pressure frame counted twice
   localparam int TOTAL_PIX = 40 + 60 + 4 * 30 + 2 * 60 + 40;
   localparam int WATCHDOG_CYCLES = 16 * TOTAL_PIX + 500;

   logic                        clk;
   logic                        rst_n;
   logic                        start_i;
   logic [LEN_W-1:0]            line_len_i;
   logic [LEN_W-1:0]            n_lines_i;
   logic [NTAPS-1:0][PIX_W-1:0] weights_i;
   logic [PIX_W-1:0]            bias_i;
   logic                        rectify_i;
   logic                        x_valid_i;
   logic [PIX_W-1:0]            x_data_i;
   logic                        y_ready_i;
   logic                        x_ready_o;
   logic                        y_valid_o;
   logic [PIX_W-1:0]            y_data_o;
   logic                        busy_o;
   logic                        done_preload_o;
   logic                        done_o;

   // frame setup seen by the model
   logic [NTAPS-1:0][PIX_W-1:0] w_set;
   logic [PIX_W-1:0]            bias_set;
   logic                        rect_set;
   logic [PIX_W-1:0]            pix_mem [4096];
   logic [1:0]                  gap_len [4096];
   logic                        rdy_pat [1024];
   logic signed [PIX_W-1:0]     exp_q [$];
   logic signed [PIX_W-1:0]     got_q [$];
   logic signed [PIX_W-1:0]     ref_q [$];

   logic [31:0] lfsr_q;
   int          acc_cnt;
   int          got_cnt;
   int          done_cnt;
   bit          frame_over;
   int          err_cnt;
   int          check_cnt;
   int          test_cnt;

   conv_engine dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         v      = {v[30:0], fb};
      end
      return v;
   endfunction

   // window at row r, column c, bottom right corner
   function automatic logic signed [PIX_W-1:0] model_out(input int len, input int r, input int c);
      longint acc;
      longint sc;
      acc = longint'($signed(bias_set)) * (longint'(1) << QF);  // integer bias
      for (int i = 0; i < KSIZE; i++) begin
         for (int j = 0; j < KSIZE; j++) begin
            acc += longint'($signed(pix_mem[(r - 2 + i) * len + c - 2 + j]))
                   * longint'($signed(w_set[i * KSIZE + j]));
         end
      end
      sc = acc >>> QF;
      if (rect_set && sc < 0) return '0;
      if (sc > 32767) return 16'sh7fff;
      if (sc < -32768) return 16'sh8000;
      return sc[PIX_W-1:0];
   endfunction

   task automatic check_value(input string name, input longint got, input longint exp);
      check_cnt++;
      assert (got == exp) else begin
         $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_true(input bit cond, input string what);
      check_cnt++;
      assert (cond) else begin
         $display("ERROR at %0t ns: %s", $time, what);
         err_cnt++;
      end
   endtask

   task automatic fill_frame(input int n_pix, input int mode);
      logic [31:0] bits;
      for (int i = 0; i < n_pix; i++) begin
         if (mode == 1) begin
            bits = take_bits(8);
            pix_mem[i] = {{8{bits[7]}}, bits[7:0]};  // small signed
         end else if (mode == 2) begin
            bits = take_bits(14);
            pix_mem[i] = {2'b01, bits[13:0]};  // large positive
         end else begin
            bits = take_bits(16);
            pix_mem[i] = bits[15:0];
         end
      end
   endtask

   task automatic random_weights();
      logic [31:0] bits;
      for (int k = 0; k < NTAPS; k++) begin
         bits = take_bits(9);
         w_set[k] = {{7{bits[8]}}, bits[8:0]};  // within +-1.0
      end
   endtask

   task automatic drive_pixels(input int n_pix, input int len, input bit stall, input bit poke);
      for (int i = 0; i < n_pix; i++) begin
         if (poke && i == len + 3) begin
            x_valid_i <= 1'b0;
            start_i   <= 1'b1;  // engine busy, strobe must be ignored
            @(posedge clk);
            start_i <= 1'b0;
         end
         if (stall) begin
            repeat (gap_len[i]) begin
               x_valid_i <= 1'b0;
               @(posedge clk);
            end
         end
         x_valid_i <= 1'b1;
         x_data_i  <= pix_mem[i];
         @(negedge clk);
         while (!x_ready_o) @(negedge clk);
         @(posedge clk);  // taken on this edge
         acc_cnt++;
      end
      x_valid_i <= 1'b0;
   endtask

   task automatic drive_ready(input bit stall);
      int cyc;
      cyc = 0;
      while (!frame_over) begin
         y_ready_i <= stall ? rdy_pat[cyc % 1024] : 1'b1;
         @(posedge clk);
         cyc++;
      end
      y_ready_i <= 1'b1;
   endtask

   // sampled at the falling edge, values hold through the next rising edge
   task automatic watch_outputs(input int len, input int n_exp);
      int post;
      post = 0;
      while (!frame_over) begin
         @(negedge clk);
         if (y_valid_o && y_ready_i) begin
            if (got_cnt < n_exp) check_value("y_data_o", $signed(y_data_o), exp_q[got_cnt]);
            else check_true(1'b0, "result taken beyond the expected count");
            got_q.push_back(y_data_o);
            got_cnt++;
         end
         if (done_o) begin
            done_cnt++;
            check_true(got_cnt == n_exp, "done_o pulsed before the last result was taken");
         end else if (done_cnt == 0) begin
            check_value("busy_o", busy_o, 1);
            check_value("done_preload_o", done_preload_o, acc_cnt >= 2 * len + 2);
         end else begin
            post++;
            if (post == 3) frame_over = 1'b1;  // a few quiet cycles after done
         end
      end
   endtask

   task automatic run_frame(input int len, input int lines, input bit stall, input bit poke);
      int          n_exp;
      logic [31:0] bits;
      n_exp = (len - 2) * (lines - 2);
      exp_q.delete();
      got_q.delete();
      for (int r = 2; r < lines; r++) begin
         for (int c = 2; c < len; c++) exp_q.push_back(model_out(len, r, c));
      end
      if (stall) begin
         for (int i = 0; i < len * lines; i++) begin
            bits = take_bits(2);
            gap_len[i] = bits[1:0];
         end
         for (int i = 0; i < 1024; i++) begin
            bits = take_bits(1);
            rdy_pat[i] = bits[0];
         end
      end
      acc_cnt    = 0;
      got_cnt    = 0;
      done_cnt   = 0;
      frame_over = 1'b0;
      @(posedge clk);
      weights_i  <= w_set;
      bias_i     <= bias_set;
      rectify_i  <= rect_set;
      line_len_i <= LEN_W'(len);
      n_lines_i  <= LEN_W'(lines);
      start_i    <= 1'b1;
      @(posedge clk);
      start_i <= 1'b0;
      fork
         drive_pixels(len * lines, len, stall, poke);
         drive_ready(stall);
         watch_outputs(len, n_exp);
      join
      check_value("result count", got_cnt, n_exp);
      check_value("done_o pulses", done_cnt, 1);
   endtask

   task automatic check_idle(input int n);
      repeat (n) begin
         @(negedge clk);
         check_value("x_ready_o", x_ready_o, 0);
         check_value("y_valid_o", y_valid_o, 0);
         check_value("busy_o", busy_o, 0);
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      test_cnt++;
      if (err_cnt == errs_before) $display("test %-26s ok", name);
      else $display("test %-26s %0d errors", name, err_cnt - errs_before);
   endtask

   task automatic identity_test();
      int errs;
      errs = err_cnt;
      fill_frame(40, 0);
      w_set = '0;
      w_set[NTAPS / 2] = PIX_W'(1 << QF);  // centre tap at 1.0
      bias_set = '0;
      rect_set = 1'b0;
      run_frame(8, 5, 1'b0, 1'b0);
      check_value("identity result count", got_q.size(), 18);
      finish_test("identity kernel", errs);
   endtask

   task automatic random_kernel_test();
      int          errs;
      logic [31:0] bits;
      errs = err_cnt;
      fill_frame(60, 1);
      random_weights();
      bits     = take_bits(8);
      bias_set = {{8{bits[7]}}, bits[7:0]};
      rect_set = 1'b0;
      run_frame(10, 6, 1'b0, 1'b0);
      finish_test("random kernel and bias", errs);
   endtask

   task automatic saturation_test();
      int errs;
      errs = err_cnt;
      fill_frame(30, 2);
      bias_set = '0;
      for (int sel = 0; sel < 4; sel++) begin
         for (int k = 0; k < NTAPS; k++) w_set[k] = (sel < 2) ? 16'h7000 : 16'h9000;
         rect_set = sel[0];
         run_frame(6, 5, 1'b0, 1'b0);
         if (got_q.size() > 0) begin
            if (sel < 2) check_value("clamped y_data_o", got_q[$], 32767);
            else check_value("clamped y_data_o", got_q[$], rect_set ? 0 : -32768);
         end
      end
      finish_test("rectifier and saturation", errs);
   endtask

   task automatic backpressure_test();
      int errs;
      errs = err_cnt;
      fill_frame(60, 0);
      random_weights();
      bias_set = '0;
      rect_set = 1'b0;
      run_frame(10, 6, 1'b0, 1'b0);
      ref_q = got_q;
      run_frame(10, 6, 1'b1, 1'b0);  // gapped input, random ready
      check_value("stalled result count", got_q.size(), ref_q.size());
      foreach (ref_q[i]) begin
         if (i < got_q.size()) check_value("stalled y_data_o", got_q[i], ref_q[i]);
      end
      finish_test("back-pressure", errs);
   endtask

   task automatic control_status_test();
      int errs;
      errs = err_cnt;
      fill_frame(40, 1);
      random_weights();
      bias_set = '0;
      rect_set = 1'b1;
      check_idle(4);
      run_frame(8, 5, 1'b0, 1'b1);
      check_idle(3);
      finish_test("control status", errs);
   endtask

   initial begin
      rst_n      = 1'b0;
      start_i    = 1'b0;
      line_len_i = '0;
      n_lines_i  = '0;
      weights_i  = '0;
      bias_i     = '0;
      rectify_i  = 1'b0;
      x_valid_i  = 1'b0;
      x_data_i   = '0;
      y_ready_i  = 1'b1;
      lfsr_q     = 32'hfea5;
      err_cnt    = 0;
      check_cnt  = 0;
      test_cnt   = 0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      identity_test();
      random_kernel_test();
      saturation_test();
      backpressure_test();
      control_status_test();
      $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, a frame never completed", WATCHDOG_CYCLES);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
hdl/conv_pkg.sv
hdl/conv_ctrl_fsm.sv
hdl/conv_linebuffer.sv
hdl/conv_sop.sv
hdl/conv_out_stage.sv
hdl/conv_engine.sv
tb/conv_engine_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= conv_engine_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal -j 0
PASS_MSG  ?= Simulation PASSED

SOURCES := $(wildcard hdl/*.sv) $(wildcard tb/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
